// ==== verilog/memtest_pkg.sv ====
package memtest_pkg;

    localparam int avl_addr_w = 27;   // Avalon word address width
    localparam int data_w     = 32;
    localparam int test_words = 64;   // Words covered by one pass

    // Idle must stay at 1 for the LEDR readout
    typedef enum logic [3:0] {
        st_init  = 4'd0,
        st_idle  = 4'd1,
        st_write = 4'd2,
        st_read  = 4'd3,
        st_rwait = 4'd4,
        st_error = 4'd5
    } state_t;

    // Single-word strobe from the test engine
    typedef struct packed {
        logic              read;
        logic              write;
        logic [31:0]       addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    // Command towards the LPDDR2 controller
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic                  burstbegin;   // First cycle of a command only
        logic [avl_addr_w-1:0] addr;
        logic [data_w-1:0]     wdata;
    } avl_cmd_t;

    typedef struct packed {
        logic        done;
        logic        fail;
        logic [15:0] err_count;   // Saturating
    } memtest_status_t;

endpackage

// ==== verilog/key_sequencer.sv ====
`timescale 1ns/1ps

module key_sequencer #(
    parameter int sample_period = 4_000_000
) (
    input  logic CLOCK_50_B5B,
    input  logic rst_n,
    input  logic key,
    output logic soft_reset_n,
    output logic global_reset_n,
    output logic start
);

    logic [31:0] tick_cnt;
    logic        tick;
    logic [4:0]  history;        // Newest sample in bit 0
    logic        release_seen;
    logic        release_q;

    assign tick = (tick_cnt == 32'(sample_period - 1));

    always_ff @(posedge CLOCK_50_B5B) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 32'd1;
        end
    end

    // KEY is active low, so an idle button fills the history with ones
    always_ff @(posedge CLOCK_50_B5B) begin
        if (!rst_n) begin
            history <= 5'b11111;
        end else if (tick) begin
            history <= {history[3:0], key};
        end
    end

    assign release_seen = (history[4:3] == 2'b01);   // Released three samples back

    always_ff @(posedge CLOCK_50_B5B) begin
        if (!rst_n) begin
            soft_reset_n   <= 1'b1;
            global_reset_n <= 1'b1;
            release_q      <= 1'b0;
            start          <= 1'b0;
        end else begin
            soft_reset_n   <= (history[1:0] != 2'b10);   // Press just sampled
            global_reset_n <= (history[3:2] != 2'b10);   // Same press, two samples on
            release_q      <= release_seen;
            start          <= release_seen & ~release_q;
        end
    end

endmodule

// ==== verilog/lpddr2_memory.sv ====
`timescale 1ns/1ps

module lpddr2_memory (
    input  logic                           CLOCK_50_B5B,
    input  logic                           rst_n,
    input  logic                           soft_reset_n,
    input  memtest_pkg::mem_req_t          req,
    output logic                           mem_ready,
    output logic [memtest_pkg::data_w-1:0] rdata,
    input  logic                           local_init_done,
    input  logic                           avl_ready,
    input  logic                           avl_rdata_valid,
    input  logic [memtest_pkg::data_w-1:0] avl_rdata,
    output memtest_pkg::avl_cmd_t          avl_cmd,
    output memtest_pkg::state_t            c_state
);

    logic rdata_load;

    assign mem_ready  = (c_state == memtest_pkg::st_idle);
    assign rdata_load = (c_state == memtest_pkg::st_rwait) && avl_rdata_valid;

    // Either reset drops back to waiting for calibration
    always_ff @(posedge CLOCK_50_B5B) begin
        if (!rst_n || !soft_reset_n) begin
            c_state <= memtest_pkg::st_init;
            avl_cmd <= '0;
        end else begin
            avl_cmd.burstbegin <= 1'b0;   // Dropped after the first command cycle
            case (c_state)
                memtest_pkg::st_init: begin
                    if (local_init_done) begin
                        c_state <= memtest_pkg::st_idle;
                    end
                end

                memtest_pkg::st_idle: begin
                    if (req.read && req.write) begin
                        c_state <= memtest_pkg::st_error;   // Illegal strobe
                    end else if (req.write) begin
                        avl_cmd.write      <= 1'b1;
                        avl_cmd.burstbegin <= 1'b1;
                        avl_cmd.addr       <= req.addr[memtest_pkg::avl_addr_w-1:0];
                        avl_cmd.wdata      <= req.wdata;
                        c_state            <= memtest_pkg::st_write;
                    end else if (req.read) begin
                        avl_cmd.read       <= 1'b1;
                        avl_cmd.burstbegin <= 1'b1;
                        avl_cmd.addr       <= req.addr[memtest_pkg::avl_addr_w-1:0];
                        c_state            <= memtest_pkg::st_read;
                    end
                end

                // Command held as is until the controller takes it
                memtest_pkg::st_write: begin
                    if (avl_ready) begin
                        avl_cmd.write <= 1'b0;
                        c_state       <= memtest_pkg::st_idle;
                    end
                end

                memtest_pkg::st_read: begin
                    if (avl_ready) begin
                        avl_cmd.read <= 1'b0;
                        c_state      <= memtest_pkg::st_rwait;
                    end
                end

                memtest_pkg::st_rwait: begin
                    if (avl_rdata_valid) begin
                        c_state <= memtest_pkg::st_idle;
                    end
                end

                memtest_pkg::st_error: begin
                    c_state <= memtest_pkg::st_error;   // Stuck until reset
                end

                default: begin
                    c_state <= memtest_pkg::st_error;
                end
            endcase
        end
    end

    // Last word read, kept until the next read returns
    always_ff @(posedge CLOCK_50_B5B) begin
        if (rdata_load) begin
            rdata <= avl_rdata;
        end
    end

endmodule

// ==== verilog/master.sv ====
`timescale 1ns/1ps

module master (
    input  logic                           CLOCK_50_B5B,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           start,
    input  logic                           mem_ready,
    input  logic [memtest_pkg::data_w-1:0] rdata,
    output memtest_pkg::mem_req_t          req,
    output logic [15:0]                    address,
    output memtest_pkg::memtest_status_t   status
);

    logic        wr_phase;
    logic        rd_phase;
    logic        rd_pending;   // Read issued, data not checked yet
    logic [15:0] addr_q;
    logic [15:0] cmp_addr;     // Address of the outstanding read
    logic        step;
    logic        last_word;
    logic        mismatch;
    logic [15:0] err_next;

    // Upper half is the inverted address so stuck data lines show up
    function automatic logic [memtest_pkg::data_w-1:0] pattern_of(input logic [15:0] a);
        return {~a, a};
    endfunction

    assign step      = run & mem_ready;   // One strobe per bridge idle period
    assign last_word = (addr_q == 16'(memtest_pkg::test_words - 1));
    assign mismatch  = rd_pending && (rdata != pattern_of(cmp_addr));

    always_comb begin
        err_next = status.err_count;
        if (mismatch && status.err_count != 16'hffff) begin
            err_next = status.err_count + 16'd1;
        end
    end

    always_comb begin
        req.read  = step & rd_phase;
        req.write = step & wr_phase;
        req.addr  = {16'd0, addr_q};
        req.wdata = pattern_of(addr_q);
    end

    // Walking address during a pass, the error count once it ends
    assign address = status.done ? status.err_count : addr_q;

    always_ff @(posedge CLOCK_50_B5B) begin
        if (!rst_n) begin
            wr_phase   <= 1'b0;
            rd_phase   <= 1'b0;
            rd_pending <= 1'b0;
            addr_q     <= '0;
            status     <= '0;
        end else if (start) begin
            wr_phase   <= 1'b1;
            rd_phase   <= 1'b0;
            rd_pending <= 1'b0;
            addr_q     <= '0;
            status     <= '0;
        end else if (step) begin
            if (wr_phase) begin
                if (last_word) begin
                    wr_phase <= 1'b0;   // Switch over to verify
                    rd_phase <= 1'b1;
                    addr_q   <= '0;
                end else begin
                    addr_q <= addr_q + 16'd1;
                end
            end

            if (rd_phase) begin
                if (last_word) begin
                    rd_phase <= 1'b0;
                end else begin
                    addr_q <= addr_q + 16'd1;
                end
            end

            // Data of the previous read is valid now that the bridge is idle
            if (rd_pending) begin
                status.err_count <= err_next;
                if (!rd_phase) begin
                    status.done <= 1'b1;
                    status.fail <= (err_next != 16'd0);
                end
            end

            rd_pending <= rd_phase;
        end
    end

    always_ff @(posedge CLOCK_50_B5B) begin
        if (step && rd_phase) begin
            cmp_addr <= addr_q;
        end
    end

endmodule

// ==== verilog/hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
    input  logic [15:0] value,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1,
    output logic [6:0]  hex2,
    output logic [6:0]  hex3
);

    // Segment order is gfedcba, low lights the segment
    function automatic logic [6:0] seg_of(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'ha:    return 7'b0001000;
            4'hb:    return 7'b0000011;   // Lower case b
            4'hc:    return 7'b1000110;
            4'hd:    return 7'b0100001;   // Lower case d
            4'he:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    assign hex0 = seg_of(value[3:0]);
    assign hex1 = seg_of(value[7:4]);
    assign hex2 = seg_of(value[11:8]);
    assign hex3 = seg_of(value[15:12]);

endmodule

// ==== verilog/baseline_c5gx.sv ====
`timescale 1ns/1ps

module baseline_c5gx #(
    parameter int sample_period = 4_000_000
) (
    input  logic                           CLOCK_50_B5B,
    input  logic                           rst_n,
    input  logic [3:0]                     KEY,
    input  logic [9:0]                     SW,
    output logic [6:0]                     HEX0,
    output logic [6:0]                     HEX1,
    output logic [6:0]                     HEX2,
    output logic [6:0]                     HEX3,
    output logic [7:0]                     LEDG,
    output logic [9:0]                     LEDR,
    output logic                           mem_global_reset_n,
    input  logic                           local_init_done,
    input  logic                           avl_ready,        // Inverse of waitrequest
    input  logic                           avl_rdata_valid,
    input  logic [memtest_pkg::data_w-1:0] avl_rdata,
    output memtest_pkg::avl_cmd_t          avl_cmd
);

    logic                           soft_reset_n;
    logic                           start;
    logic                           mem_ready;
    logic [memtest_pkg::data_w-1:0] rdata;
    logic [15:0]                    hex_value;
    memtest_pkg::mem_req_t          req;
    memtest_pkg::state_t            c_state;
    memtest_pkg::memtest_status_t   status;

    key_sequencer #(
        .sample_period(sample_period)
    ) u_key_sequencer (
        .CLOCK_50_B5B  (CLOCK_50_B5B),
        .rst_n         (rst_n),
        .key           (KEY[0]),
        .soft_reset_n  (soft_reset_n),
        .global_reset_n(mem_global_reset_n),
        .start         (start)
    );

    lpddr2_memory u_lpddr2_memory (
        .CLOCK_50_B5B   (CLOCK_50_B5B),
        .rst_n          (rst_n),
        .soft_reset_n   (soft_reset_n),
        .req            (req),
        .mem_ready      (mem_ready),
        .rdata          (rdata),
        .local_init_done(local_init_done),
        .avl_ready      (avl_ready),
        .avl_rdata_valid(avl_rdata_valid),
        .avl_rdata      (avl_rdata),
        .avl_cmd        (avl_cmd),
        .c_state        (c_state)
    );

    master u_master (
        .CLOCK_50_B5B(CLOCK_50_B5B),
        .rst_n       (rst_n),
        .run         (SW[1]),   // Pause switch
        .start       (start),
        .mem_ready   (mem_ready),
        .rdata       (rdata),
        .req         (req),
        .address     (hex_value),
        .status      (status)
    );

    hex_display u_hex_display (
        .value(hex_value),
        .hex0 (HEX0),
        .hex1 (HEX1),
        .hex2 (HEX2),
        .hex3 (HEX3)
    );

    assign LEDG = {6'd0, status.fail, status.done};
    assign LEDR = {6'd0, c_state};   // Bridge state for bring-up

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

// ==== test/baseline_c5gx_props.sv ====
`timescale 1ns/1ps

module baseline_c5gx_props (
    input logic                  CLOCK_50_B5B,
    input logic                  rst_n,
    input logic                  soft_reset_n,
    input logic                  start,
    input logic [9:0]            SW,
    input logic [7:0]            LEDG,
    input logic [9:0]            LEDR,
    input logic [6:0]            HEX0,
    input logic [6:0]            HEX1,
    input logic [6:0]            HEX2,
    input logic [6:0]            HEX3,
    input logic                  mem_global_reset_n,
    input logic                  local_init_done,
    input logic                  avl_ready,
    input memtest_pkg::avl_cmd_t avl_cmd
);

    int   fail_count = 0;
    logic pulse_seen;   // Global reset pulse since the last start

    always_ff @(posedge CLOCK_50_B5B) begin
        if (!rst_n || start) begin
            pulse_seen <= 1'b0;
        end else if (!mem_global_reset_n) begin
            pulse_seen <= 1'b1;
        end
    end

    reset_clears: assert property (@(posedge CLOCK_50_B5B)
        !rst_n |=> (avl_cmd == '0 && LEDG == 8'd0 && LEDR[3:0] == 4'd0 && !start))
        else begin
            fail_count++;
            $error("Outputs not cleared by reset");
        end

    // Leaves st_init one cycle after calibration is reported
    init_to_idle: assert property (@(posedge CLOCK_50_B5B) disable iff (!rst_n)
        soft_reset_n && LEDR[3:0] == 4'd0 |=> LEDR[3:0] == {3'd0, $past(local_init_done)})
        else begin
            fail_count++;
            $error("Bridge state wrong while waiting for calibration");
        end

    cmd_held: assert property (@(posedge CLOCK_50_B5B) disable iff (!rst_n || !soft_reset_n)
        (avl_cmd.read || avl_cmd.write) && !avl_ready
        |=> $stable({avl_cmd.read, avl_cmd.write, avl_cmd.addr, avl_cmd.wdata}))
        else begin
            fail_count++;
            $error("Avalon command changed while the controller was busy");
        end

    burst_first: assert property (@(posedge CLOCK_50_B5B) disable iff (!rst_n || !soft_reset_n)
        avl_cmd.burstbegin == $rose(avl_cmd.read || avl_cmd.write))
        else begin
            fail_count++;
            $error("burstbegin not limited to the first command cycle");
        end

    write_pattern: assert property (@(posedge CLOCK_50_B5B) disable iff (!rst_n)
        avl_cmd.write |-> avl_cmd.wdata == {~avl_cmd.addr[15:0], avl_cmd.addr[15:0]})
        else begin
            fail_count++;
            $error("Write data does not follow the address pattern");
        end

    key_order: assert property (@(posedge CLOCK_50_B5B) disable iff (!rst_n)
        start |-> pulse_seen)
        else begin
            fail_count++;
            $error("Pass started without a memory global reset pulse");
        end

    // Paused engine keeps its display and starts no command
    pause_freeze: assert property (@(posedge CLOCK_50_B5B) disable iff (!rst_n)
        !$past(SW[1]) && !$past(start)
        |-> $stable({HEX3, HEX2, HEX1, HEX0}) && !avl_cmd.burstbegin)
        else begin
            fail_count++;
            $error("Activity seen while the run switch was off");
        end

endmodule

// ==== test/tb_baseline_c5gx.sv ====
`timescale 1ns/1ps

module tb_baseline_c5gx;

    localparam int         words      = memtest_pkg::test_words;
    localparam int         max_cycles = 3 * 2 * words * 12 + 2000;
    localparam logic [6:0] seg_zero   = 7'b1000000;   // gfedcba, low is lit
    localparam logic [6:0] seg_one    = 7'b1111001;

    logic                  CLOCK_50_B5B;
    logic                  rst_n;
    logic [3:0]            KEY;
    logic [9:0]            SW;
    logic [6:0]            HEX0;
    logic [6:0]            HEX1;
    logic [6:0]            HEX2;
    logic [6:0]            HEX3;
    logic [7:0]            LEDG;
    logic [9:0]            LEDR;
    logic                  mem_global_reset_n;
    logic                  local_init_done;
    logic                  avl_ready;
    logic                  avl_rdata_valid;
    logic [31:0]           avl_rdata;
    memtest_pkg::avl_cmd_t avl_cmd;

    logic [31:0] mem [words];
    logic        fault_en;     // Flip bit 0 when fault_addr is read
    logic [5:0]  fault_addr;
    logic [27:0] hex_held;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          cycles = 0;

    clock_gen u_clock_gen (.clk(CLOCK_50_B5B));

    baseline_c5gx #(.sample_period(4)) uut (.*);

    bind baseline_c5gx baseline_c5gx_props u_props (.*);

    function automatic int total_errors();
        return errors + uut.u_props.fail_count;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50_B5B);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        new_errors = total_errors() - errors_at_start;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d error(s)", tests_run, name, new_errors);
        end
        errors_at_start = total_errors();
    endtask

    // Press long enough for the sampler to see press and release
    task automatic press_key();
        KEY[0] = 1'b0;
        wait_cycles(24);
        KEY[0] = 1'b1;
    endtask

    task automatic wait_pass_start();
        while (LEDG[0])
            wait_cycles(1);   // Previous result clears on start
    endtask

    task automatic wait_pass_end();
        while (!LEDG[0])
            wait_cycles(1);
    endtask

    task automatic check_result(input logic fail, input logic [6:0] digit0);
        check_value("LEDG", 32'(LEDG), {30'd0, fail, 1'b1});
        check_value("HEX3..HEX0", {4'd0, HEX3, HEX2, HEX1, HEX0},
                    {4'd0, seg_zero, seg_zero, seg_zero, digit0});
    endtask

    // Controller model with random back-pressure and read latency
    initial begin : controller
        int         stall;
        int         rd_delay;
        logic       rd_busy;
        logic [5:0] rd_addr;
        void'($urandom(32'h263fae3e));
        fault_addr      = 6'($urandom_range(63, 0));
        avl_ready       = 1'b0;
        avl_rdata_valid = 1'b0;
        avl_rdata       = '0;
        stall           = 0;
        rd_delay        = 0;
        rd_busy         = 1'b0;
        rd_addr         = '0;
        for (int i = 0; i < words; i++)
            mem[i] = 32'hbad0_0000 | 32'(i);
        forever begin
            @(posedge CLOCK_50_B5B);
            #1;
            avl_ready       = 1'b0;
            avl_rdata_valid = 1'b0;
            if (rd_busy) begin
                if (rd_delay == 0) begin
                    avl_rdata_valid = 1'b1;
                    avl_rdata       = mem[rd_addr];
                    if (fault_en && rd_addr == fault_addr)
                        avl_rdata[0] = ~avl_rdata[0];
                    rd_busy = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            if (avl_cmd.read || avl_cmd.write) begin
                if (avl_cmd.burstbegin)
                    stall = int'($urandom_range(3, 0));
                if (stall > 0) begin
                    stall--;
                end else begin
                    avl_ready = 1'b1;   // Taken at the next edge
                    if (avl_cmd.write) begin
                        mem[avl_cmd.addr[5:0]] = avl_cmd.wdata;
                    end else begin
                        rd_busy  = 1'b1;
                        rd_addr  = avl_cmd.addr[5:0];
                        rd_delay = int'($urandom_range(3, 0));
                    end
                end
            end
        end
    end

    always @(posedge CLOCK_50_B5B) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        rst_n           = 1'b0;
        KEY             = 4'hf;
        SW              = 10'b10;   // Run switch on
        local_init_done = 1'b0;
        fault_en        = 1'b0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        wait_cycles(10);
        rst_n = 1'b1;

        wait_cycles(5);
        check_value("LEDR before calibration", 32'(LEDR), 32'd0);
        check_value("LEDG after reset", 32'(LEDG), 32'd0);
        local_init_done = 1'b1;
        wait_cycles(2);
        check_value("LEDR after calibration", 32'(LEDR), 32'd1);
        finish_test("reset and init");

        press_key();
        wait_pass_start();
        wait_pass_end();
        check_result(1'b0, seg_zero);
        finish_test("clean pass");

        fault_en = 1'b1;
        press_key();
        wait_pass_start();
        wait_pass_end();
        check_result(1'b1, seg_one);
        fault_en = 1'b0;
        finish_test("single fault");

        press_key();
        wait_pass_start();
        wait_cycles(60);
        SW[1] = 1'b0;
        wait_cycles(2);
        hex_held = {HEX3, HEX2, HEX1, HEX0};
        wait_cycles(40);
        check_value("HEX while paused", {4'd0, HEX3, HEX2, HEX1, HEX0}, {4'd0, hex_held});
        SW[1] = 1'b1;
        wait_pass_end();
        check_result(1'b0, seg_zero);
        finish_test("pause and resume");

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== baseline_c5gx.f ====
verilog/memtest_pkg.sv
verilog/key_sequencer.sv
verilog/lpddr2_memory.sv
verilog/master.sv
verilog/hex_display.sv
verilog/baseline_c5gx.sv
test/clock_gen.sv
test/baseline_c5gx_props.sv
test/tb_baseline_c5gx.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_baseline_c5gx
FILELIST = baseline_c5gx.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
